// ==== rtl/cnnShapePkg.sv ====
// image geometry, data widths and row types for the single channel conv layer
package cnnShapePkg;

	localparam int imgW = 6; // pixels per unpadded row
	localparam int imgH = 6; // rows per frame
	localparam int filtF = 3; // square filter edge
	localparam int padW = imgW + 2; // one zero pixel each side
	localparam int pixW = 8; // pixel and weight width
	localparam int accW = 32; // MAC sum width

	// element 0 is the leftmost pixel in every row type
	typedef logic [0:imgW-1][pixW-1:0] pixRowT; // 48 bits
	typedef logic [0:padW-1][pixW-1:0] padRowT; // 64 bits
	typedef logic [0:filtF*filtF-1][pixW-1:0] weightsT; // signed taps in raster order
	typedef logic [0:imgW-1][accW-1:0] accRowT; // 192 bits of signed sums

endpackage

// ==== rtl/cnnTimingPkg.sv ====
// MAC sequence timing and output quantization constants
package cnnTimingPkg;

	localparam int macCount = cnnShapePkg::filtF * cnnShapePkg::filtF; // taps per pixel
	localparam int seqLen = macCount + 3; // cycles windowValid stays high
	localparam int validCount = macCount + 1; // counter value for the sum strobe
	localparam int quantShift = 4; // right shift ahead of saturation

endpackage

// ==== rtl/windowIf.sv ====
`timescale 1ns/100ps
// three padded lines plus valid level from the line buffer to the conv engine
interface windowIf;

	cnnShapePkg::padRowT top; // line above the output row
	cnnShapePkg::padRowT mid; // line of the output row
	cnnShapePkg::padRowT bot; // line below
	logic windowValid; // held high for one full sequence

	modport source (
		output top, mid, bot, windowValid
	);

	modport sink (
		input top, mid, bot, windowValid
	);

endinterface

// ==== rtl/rowIngest.sv ====
`timescale 1ns/100ps
// pads rows, keeps the three-line buffer and times each conv window
module rowIngest (
	input logic clk,
	input logic reset,
	input cnnShapePkg::pixRowT pixelRow, // unpadded row from the source
	input logic rowValid, // one-cycle strobe
	windowIf.source win,
	output logic rowReady, // source may send next row
	output logic frameDone // pulse as the bottom window ends
);

	cnnShapePkg::padRowT padded; // row with zero border
	logic [$clog2(cnnShapePkg::imgH+1)-1:0] rowCnt; // rows taken this frame
	logic [$clog2(cnnTimingPkg::seqLen)-1:0] winCnt; // cycles into window
	logic bottomPend; // zero line loaded, waiting one low cycle
	logic bottomWin; // running the frame's last window
	logic firstRow;
	logic winLast; // final high cycle of a window
	logic loadBottom; // queue the zero bottom line as the last input window ends

	assign padded = {{cnnShapePkg::pixW{1'b0}}, pixelRow, {cnnShapePkg::pixW{1'b0}}};
	assign firstRow = (rowCnt == '0);
	assign winLast = win.windowValid && (int'(winCnt) == cnnTimingPkg::seqLen - 1);
	assign loadBottom = winLast && !bottomWin && (int'(rowCnt) == cnnShapePkg::imgH);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rowReady <= 1'b1;
			rowCnt <= '0;
			winCnt <= '0;
			win.windowValid <= 1'b0;
			bottomPend <= 1'b0;
			bottomWin <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			frameDone <= 1'b0; // pulse default
			if (rowValid) begin
				rowReady <= 1'b0;
				rowCnt <= rowCnt + 1'b1;
				if (!firstRow) begin // row 0 only fills the buffer
					win.windowValid <= 1'b1;
					winCnt <= '0;
				end
			end else if (bottomPend) begin
				bottomPend <= 1'b0; // start bottom window after the gap cycle
				bottomWin <= 1'b1;
				win.windowValid <= 1'b1;
				winCnt <= '0;
			end else if (winLast) begin
				win.windowValid <= 1'b0;
				if (bottomWin) begin
					bottomWin <= 1'b0;
					frameDone <= 1'b1;
					rowCnt <= '0; // next row starts a new frame
				end else if (loadBottom) begin
					bottomPend <= 1'b1;
				end
			end else if (win.windowValid) begin
				winCnt <= winCnt + 1'b1;
			end else if (!rowReady) begin
				rowReady <= 1'b1; // accept next row when idle
			end
		end
	end

	// line buffer shifting upward on each row
	always_ff @(posedge clk) begin
		if (rowValid) begin
			win.top <= firstRow ? '0 : win.mid;
			win.mid <= firstRow ? '0 : win.bot; // zero line above row 0
			win.bot <= padded;
		end else if (loadBottom) begin
			win.top <= win.mid;
			win.mid <= win.bot;
			win.bot <= '0; // zero line below the last row
		end
	end

	assert property (@(posedge clk) disable iff (reset) rowValid |-> rowReady)
		else $error("rowValid while rowReady low");

endmodule

// ==== rtl/convUnit.sv ====
`timescale 1ns/100ps
// serial 3x3 multiply-accumulate for one output pixel
module convUnit (
	input logic clk,
	input logic clear, // zeroes index and sum
	input logic [0:cnnShapePkg::filtF-1][cnnShapePkg::pixW-1:0] taps0, // upper line
	input logic [0:cnnShapePkg::filtF-1][cnnShapePkg::pixW-1:0] taps1,
	input logic [0:cnnShapePkg::filtF-1][cnnShapePkg::pixW-1:0] taps2, // lower line
	input cnnShapePkg::weightsT weights,
	output logic signed [cnnShapePkg::accW-1:0] result
);

	logic [0:cnnTimingPkg::macCount-1][cnnShapePkg::pixW-1:0] patch; // raster order
	logic [$clog2(cnnTimingPkg::macCount+1)-1:0] tapIdx;
	logic tapActive; // index still inside the patch
	logic [cnnShapePkg::pixW-1:0] pix; // unsigned pixel
	logic signed [cnnShapePkg::pixW-1:0] wgt;
	logic signed [cnnShapePkg::accW-1:0] prod; // sign-extended product

	assign patch = {taps0, taps1, taps2};
	assign tapActive = (int'(tapIdx) < cnnTimingPkg::macCount);

	always_comb begin
		pix = '0;
		wgt = '0;
		if (tapActive) begin
			pix = patch[tapIdx];
			wgt = $signed(weights[tapIdx]);
		end
		prod = $signed({1'b0, pix}) * wgt; // zero-extend pixel and keep weight sign
	end

	always_ff @(posedge clk) begin
		if (clear) begin
			tapIdx <= '0;
			result <= '0;
		end else if (tapActive) begin
			tapIdx <= tapIdx + 1'b1; // stops at nine
			result <= result + prod;
		end
	end

endmodule

// ==== rtl/convLayerSingle.sv ====
`timescale 1ns/100ps
// row conv engine with one MAC unit per output pixel and a shared sequencer
module convLayerSingle (
	input logic clk,
	input logic reset,
	windowIf.sink win,
	input cnnShapePkg::weightsT weights, // steady for the frame
	output cnnShapePkg::accRowT sumRow,
	output logic sumValid // one-cycle strobe per window
);

	logic clearAcc; // held high between sequences
	logic [$clog2(cnnTimingPkg::seqLen)-1:0] seqCnt;

	// unit n sees padded columns n to n+2
	for (genvar n = 0; n < cnnShapePkg::imgW; n++) begin : gUnit
		convUnit unit (
			.clk(clk),
			.clear(clearAcc),
			.taps0(win.top[n +: cnnShapePkg::filtF]),
			.taps1(win.mid[n +: cnnShapePkg::filtF]),
			.taps2(win.bot[n +: cnnShapePkg::filtF]),
			.weights(weights),
			.result(sumRow[n])
		);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			seqCnt <= '0;
			clearAcc <= 1'b1;
			sumValid <= 1'b0;
		end else if (!win.windowValid) begin
			seqCnt <= '0; // hold units in clear without a window
			clearAcc <= 1'b1;
			sumValid <= 1'b0;
		end else if (int'(seqCnt) == cnnTimingPkg::validCount) begin
			seqCnt <= seqCnt + 1'b1;
			sumValid <= 1'b1; // all taps summed
		end else if (int'(seqCnt) == cnnTimingPkg::seqLen - 1) begin
			seqCnt <= '0;
			clearAcc <= 1'b1;
			sumValid <= 1'b0;
		end else begin
			seqCnt <= seqCnt + 1'b1;
			clearAcc <= 1'b0; // units run taps
			sumValid <= 1'b0;
		end
	end

	// source must keep the window for the whole sequence
	assert property (@(posedge clk) disable iff (reset)
		$fell(win.windowValid) |-> (seqCnt == '0))
		else $error("windowValid dropped mid sequence");

endmodule

// ==== rtl/reluQuant.sv ====
`timescale 1ns/100ps
// ReLU, shift and 8-bit saturation of one result row, registered
module reluQuant (
	input logic clk,
	input logic reset,
	input cnnShapePkg::accRowT sumRow,
	input logic sumValid,
	output cnnShapePkg::pixRowT outRow,
	output logic outValid
);

	cnnShapePkg::pixRowT quantRow; // next output row

	function automatic logic [cnnShapePkg::pixW-1:0] quantize(
		input logic [cnnShapePkg::accW-1:0] s
	);
		logic [cnnShapePkg::accW-1:0] shifted;
		shifted = s >> cnnTimingPkg::quantShift;
		if (s[cnnShapePkg::accW-1])
			return '0; // negative sum
		if (|shifted[cnnShapePkg::accW-1:cnnShapePkg::pixW])
			return '1; // saturate at 255
		return shifted[cnnShapePkg::pixW-1:0];
	endfunction

	always_comb begin
		for (int n = 0; n < cnnShapePkg::imgW; n++)
			quantRow[n] = quantize(sumRow[n]);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= sumValid; // one cycle behind the sums
	end

	always_ff @(posedge clk) begin
		if (sumValid)
			outRow <= quantRow;
	end

	assert property (@(posedge clk) disable iff (reset) outValid |=> !outValid)
		else $error("outValid high two cycles in a row");

endmodule

// ==== rtl/convTop.sv ====
`timescale 1ns/100ps
// same-padded 3x3 conv layer for one channel with line buffer, MAC engine and quantizer
module convTop (
	input logic clk,
	input logic reset,
	input cnnShapePkg::pixRowT pixelRow, // unpadded input row
	input logic rowValid, // only while rowReady
	input cnnShapePkg::weightsT weights, // held for a frame
	output logic rowReady,
	output cnnShapePkg::pixRowT outRow,
	output logic outValid,
	output logic frameDone
);

	windowIf winBus (); // line buffer to engine
	cnnShapePkg::accRowT sumRow; // raw signed sums
	logic sumValid;

	rowIngest ingest (
		.clk(clk),
		.reset(reset),
		.pixelRow(pixelRow),
		.rowValid(rowValid),
		.win(winBus.source),
		.rowReady(rowReady),
		.frameDone(frameDone)
	);

	convLayerSingle engine (
		.clk(clk),
		.reset(reset),
		.win(winBus.sink),
		.weights(weights),
		.sumRow(sumRow),
		.sumValid(sumValid)
	);

	reluQuant quant (
		.clk(clk),
		.reset(reset),
		.sumRow(sumRow),
		.sumValid(sumValid),
		.outRow(outRow),
		.outValid(outValid)
	);

endmodule

// ==== tests/tbConvTop.sv ====
// testbench for convTop that streams two frames from a data file and checks every output row
`timescale 1ns/100ps
module tbConvTop;

	localparam string dataFile = "tests/convInput.txt";
	localparam int frames = 2;
	localparam int imgH = cnnShapePkg::imgH;
	localparam int rowsTotal = frames * imgH; // input rows, also output rows
	localparam int linesPerFrame = 1 + 2 * imgH; // weights, inputs, expected
	localparam int rowBits = cnnShapePkg::imgW * cnnShapePkg::pixW;
	localparam int cycleLimit = (rowsTotal + frames) * (cnnTimingPkg::seqLen + 6) + 200;

	logic clk;
	logic reset;
	cnnShapePkg::pixRowT pixelRow;
	logic rowValid;
	cnnShapePkg::weightsT weights;
	logic rowReady;
	cnnShapePkg::pixRowT outRow;
	logic outValid;
	logic frameDone;

	cnnShapePkg::weightsT frameWeights [frames];
	cnnShapePkg::pixRowT inRows [rowsTotal];
	cnnShapePkg::pixRowT expRows [rowsTotal]; // expected rows from the file
	int outCount = 0; // rows seen with outValid
	int doneCount = 0; // frameDone cycles
	int extraRows = 0;
	int rowErrors [frames]; // wrong rows per frame
	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;
	logic [15:0] lfsrState;

	convTop dut (
		.clk(clk),
		.reset(reset),
		.pixelRow(pixelRow),
		.rowValid(rowValid),
		.weights(weights),
		.rowReady(rowReady),
		.outRow(outRow),
		.outValid(outValid),
		.frameDone(frameDone)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// 16-bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	task automatic pickGap(output int gap); // 0 to 3 idle cycles
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			gap = (gap << 1) | int'(lfsrState[0]); // one step per bit
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	task automatic readData(output bit ok);
		int fd;
		int got;
		int idx;
		int k;
		string line;
		logic [71:0] value;
		ok = 1'b0;
		idx = 0;
		fd = $fopen(dataFile, "r");
		if (fd == 0)
			return;
		while (!$feof(fd) && idx < frames * linesPerFrame) begin
			line = "";
			got = $fgets(line, fd);
			if (got > 0 && line.getc(0) != 8'h23) begin // skip lines starting with #
				if ($sscanf(line, "%h", value) == 1) begin
					k = idx % linesPerFrame;
					if (k == 0)
						frameWeights[idx / linesPerFrame] = value;
					else if (k <= imgH)
						inRows[(idx / linesPerFrame) * imgH + k - 1] = value[rowBits-1:0];
					else
						expRows[(idx / linesPerFrame) * imgH + k - 1 - imgH] = value[rowBits-1:0];
					idx++;
				end
			end
		end
		$fclose(fd);
		ok = (idx == frames * linesPerFrame); // every line found
	endtask

	task automatic sendRow(input cnnShapePkg::pixRowT row, input int gap);
		@(negedge clk); // rowReady settled here
		while (rowReady !== 1'b1)
			@(negedge clk);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		rowValid <= 1'b1; // one-cycle strobe
		pixelRow <= row;
		@(posedge clk);
		rowValid <= 1'b0;
	endtask

	task automatic reportTest(input string name, input bit ok);
		if (ok) begin
			passCount++;
			$display("%s: ok", name);
		end else begin
			failCount++;
			$display("%s: FAILED", name);
		end
	endtask

	// output checker sampling mid cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (frameDone)
				doneCount++;
			if (outValid) begin
				if (outCount >= rowsTotal) begin
					$display("output row %0d at %0t has no input row behind it", outCount, $time);
					extraRows++;
				end else if (outRow !== expRows[outCount]) begin
					$display("mismatch at %0t: row %0d expected %h got %h", $time, outCount,
						expRows[outCount], outRow);
					rowErrors[outCount / imgH]++;
				end
				outCount++;
			end
		end
	end

	// watchdog
	initial begin
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("run did not finish within %0d cycles", cycleLimit);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		bit loadOk;
		bit ok;
		bit frameEndOk;
		int waited;
		int gap;
		reset = 1'b1;
		rowValid = 1'b0;
		pixelRow = '0;
		weights = '0;
		lfsrState = 16'd50551;
		frameEndOk = 1'b1;
		readData(loadOk);
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		if (!loadOk) begin
			$display("data file %s could not be read completely", dataFile);
			failCount++;
		end else begin
			@(negedge clk);
			ok = 1'b1;
			if (rowReady !== 1'b1) begin
				$display("mismatch at %0t: rowReady not high after reset", $time);
				ok = 1'b0;
			end
			if (outValid !== 1'b0 || frameDone !== 1'b0) begin
				$display("mismatch at %0t: outValid or frameDone high after reset", $time);
				ok = 1'b0;
			end
			reportTest("test 1 after reset", ok);
			for (int f = 0; f < frames; f++) begin
				@(posedge clk);
				weights <= frameWeights[f]; // held for the whole frame
				for (int r = 0; r < imgH; r++) begin
					gap = 0;
					if (f > 0)
						pickGap(gap); // random pacing on frame 2
					sendRow(inRows[f * imgH + r], gap);
					if (f == 0 && r == 0) begin
						waited = 0;
						ok = 1'b1;
						do begin
							@(negedge clk);
							waited++;
						end while (rowReady !== 1'b1 && waited < 8);
						if (rowReady !== 1'b1) begin
							$display("rowReady did not come back after row 0");
							ok = 1'b0;
						end else if (waited > 2) begin
							$display("mismatch at %0t: rowReady back after %0d cycles, expected 1",
								$time, waited - 1);
							ok = 1'b0;
						end
						repeat (cnnTimingPkg::seqLen + 4) @(negedge clk); // room for a stray window
						if (outCount != 0) begin
							$display("mismatch at %0t: output row produced by row 0 alone", $time);
							ok = 1'b0;
						end
						reportTest("test 2 row 0 alone", ok);
					end
				end
				// last row of the frame comes from the bottom window without more input
				while (outCount < (f + 1) * imgH)
					@(negedge clk);
				repeat (4) @(negedge clk);
				if (doneCount != f + 1) begin
					$display("mismatch at %0t: frameDone seen %0d times after frame %0d, expected %0d",
						$time, doneCount, f + 1, f + 1);
					frameEndOk = 1'b0;
				end
				reportTest(f == 0 ? "test 3 frame 1 output" : "test 5 frame 2 output",
					rowErrors[f] == 0);
			end
			reportTest("test 4 frame end", frameEndOk);
			ok = (outCount == rowsTotal) && (extraRows == 0);
			if (!ok)
				$display("mismatch at %0t: %0d output rows for %0d input rows", $time, outCount,
					rowsTotal);
			reportTest("test 6 row count", ok);
		end
		$display("tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== tests/convInput.txt ====
# per frame: one weights line (9 signed bytes, raster order), six input rows, six expected rows
# all values hex, the leftmost byte is tap 0 or pixel 0
00FC00FC20FC00FC00
0A141E28323C
00C800646464
05050564FF64
102030646464
000000000000
FFFFFF080808
0F002D233252
00FF008C4987
04000055FF56
162E3D8A5696
000000000000
FFFFFF000C0E
1000000020000000F0
010203040506
0A141E28323C
640064006400
070707070707
C89664321900
0009121B242D
00000000000C
14003E00687D
C103D517E932
000E00590E72
FFFFB4470C07
00DABA9A7A73

// ==== tb.f ====
rtl/cnnShapePkg.sv
rtl/cnnTimingPkg.sv
rtl/windowIf.sv
rtl/rowIngest.sv
rtl/convUnit.sv
rtl/convLayerSingle.sv
rtl/reluQuant.sv
rtl/convTop.sv
tests/tbConvTop.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tbConvTop -f tb.f -o simConv \
	&& ./obj_dir/simConv | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }
grep -q "Testbench failed" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0
